//--- common/blimp_isa_pkg.sv
/*
 * ISA subset of the core: NOP, ADD, ADDI and MUL only.
 * Fixed 32-bit encoding, 32 registers, r0 hardwired to zero.
 * Unknown opcodes are treated as NOP by the decoder.
 */

package blimp_isa_pkg;

  // Datapath and register file geometry
  localparam int XLEN          = 32;
  localparam int NUM_REGS      = 32;
  localparam int REG_ADDR_BITS = $clog2(NUM_REGS);

  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_ADDI = 4'd2,
    OP_MUL  = 4'd3
  } t_opcode;

  // Raw instruction word, MSB first
  typedef struct packed {
    logic [3:0]               opcode;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [12:0]              imm;
  } t_inst;

  // Decoder output, immediate already sign-extended
  typedef struct packed {
    t_opcode                  op;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [XLEN-1:0]          imm;
  } t_dec_inst;

  // Register-register form, immediate field zero
  function automatic logic [31:0] enc_r(t_opcode op, logic [4:0] rd, logic [4:0] rs1,
                                        logic [4:0] rs2);
    return {op, rd, rs1, rs2, 13'd0};
  endfunction

  // Register-immediate form, rs2 field zero
  function automatic logic [31:0] enc_i(t_opcode op, logic [4:0] rd, logic [4:0] rs1,
                                        logic [12:0] imm);
    return {op, rd, rs1, 5'd0, imm};
  endfunction

endpackage

//--- common/blimp_uarch_pkg.sv
/*
 * Microarchitecture structs shared between the pipeline units.
 * Sequence numbers wrap at 2**SEQ_NUM_BITS and are only informative.
 */

package blimp_uarch_pkg;

  import blimp_isa_pkg::*;

  localparam int SEQ_NUM_BITS = 5;

  typedef logic [SEQ_NUM_BITS-1:0] t_seq_num;

  // Instruction memory, one response per request
  typedef struct packed {
    logic            val;
    logic [XLEN-1:0] addr;
  } t_mem_req;

  typedef struct packed {
    logic            val;
    logic [XLEN-1:0] data;
  } t_mem_resp;

  // Decode to execute, operands already read
  typedef struct packed {
    logic [XLEN-1:0]          pc;
    t_opcode                  op;
    logic [REG_ADDR_BITS-1:0] waddr;
    logic                     wen;
    logic [XLEN-1:0]          op_a;
    logic [XLEN-1:0]          op_b;
    t_seq_num                 seq_num;
  } t_issue;

  // Execute to writeback
  typedef struct packed {
    logic [XLEN-1:0]          pc;
    logic [REG_ADDR_BITS-1:0] waddr;
    logic                     wen;
    logic [XLEN-1:0]          wdata;
    t_seq_num                 seq_num;
  } t_result;

  // Commit strobe, also the exported trace
  typedef struct packed {
    logic                     val;
    logic [XLEN-1:0]          pc;
    logic [REG_ADDR_BITS-1:0] waddr;
    logic                     wen;
    logic [XLEN-1:0]          wdata;
    t_seq_num                 seq_num;
  } t_commit;

endpackage

//--- logic/pipe_reg.sv
/*
 * One-entry valid/ready pipeline register, payload type set by the user.
 * Full throughput: a new entry may load in the cycle the old one drains.
 */

`timescale 1ns/1ps

module pipe_reg #(
  parameter type t_payload = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_val,
  output logic     in_rdy,
  input  t_payload in_data,
  output logic     out_val,
  input  logic     out_rdy,
  output t_payload out_data
);

  logic     val_q;
  t_payload data_q;

  // Empty, or draining this cycle
  assign in_rdy = !val_q || out_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      val_q <= 1'b0;
    end else if (in_rdy) begin
      val_q <= in_val;
    end
  end

  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      data_q <= in_data;
    end
  end

  assign out_val  = val_q;
  assign out_data = data_q;

  // Stalled entry stays put
  a_hold_stall: assert property (@(posedge clk) disable iff (!rst_n)
    out_val && !out_rdy |=> out_val && $stable(out_data))
    else $error("pipe_reg: output changed under back-pressure");

endmodule

//--- fetch/fetch.sv
/*
 * Fetch unit. One outstanding request, memory answers exactly one cycle later.
 * No branches, so the PC only ever advances by 4.
 */

`timescale 1ns/1ps

module fetch
  import blimp_uarch_pkg::*;
#(
  parameter logic [31:0] p_rst_addr = 32'h0
) (
  input  logic        clk,
  input  logic        rst_n,
  output t_mem_req    imem_req,
  input  t_mem_resp   imem_resp,
  output logic        inst_val,
  input  logic        inst_rdy,
  output logic [31:0] inst,
  output logic [31:0] inst_pc
);

  logic [31:0] pc;
  logic        fetch_en;
  logic        req_pending;
  logic        slot_val;
  logic [31:0] slot_inst;
  logic [31:0] slot_pc;
  logic        req_fire;
  logic        slot_xfer;

  assign slot_xfer = slot_val && inst_rdy;

  // Request only if the slot will be free when the response lands
  assign req_fire = fetch_en && !req_pending && (!slot_val || inst_rdy);

  assign imem_req.val  = req_fire;
  assign imem_req.addr = pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc          <= p_rst_addr;
      fetch_en    <= 1'b0;
      req_pending <= 1'b0;
      slot_val    <= 1'b0;
    end else begin
      // Hold off one cycle out of reset
      fetch_en <= 1'b1;
      if (req_fire) begin
        req_pending <= 1'b1;
      end else if (imem_resp.val) begin
        req_pending <= 1'b0;
      end
      // Response always finds the slot empty
      if (imem_resp.val) begin
        slot_val <= 1'b1;
        pc       <= pc + 32'd4;
      end else if (slot_xfer) begin
        slot_val <= 1'b0;
      end
    end
  end

  // Slot payload, PC still points at the returning word
  always_ff @(posedge clk) begin
    if (imem_resp.val) begin
      slot_inst <= imem_resp.data;
      slot_pc   <= pc;
    end
  end

  assign inst_val = slot_val;
  assign inst     = slot_inst;
  assign inst_pc  = slot_pc;

  // Memory must never answer unasked
  a_resp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
    imem_resp.val |-> req_pending)
    else $error("fetch: response without outstanding request");

endmodule

//--- decode/decode_issue.sv
/*
 * Decode and issue. Holds the register file and a per-register scoreboard.
 * Issues in order, one per cycle, stalling on RAW and WAW hazards.
 * Same-cycle commit is bypassed into operand read and hazard check.
 */

`timescale 1ns/1ps

module decode_issue
  import blimp_isa_pkg::*;
  import blimp_uarch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        inst_val,
  output logic        inst_rdy,
  input  logic [31:0] inst,
  input  logic [31:0] inst_pc,
  output t_issue      alu_issue,
  output logic        alu_val,
  input  logic        alu_rdy,
  output t_issue      mul_issue,
  output logic        mul_val,
  input  logic        mul_rdy,
  input  t_commit     commit
);

  t_inst           raw;
  t_dec_inst       dec;
  t_issue          iss;
  logic [XLEN-1:0] rf [NUM_REGS];
  logic [NUM_REGS-1:0] sb;
  logic [NUM_REGS-1:0] clr_mask;
  logic [NUM_REGS-1:0] set_mask;
  logic [NUM_REGS-1:0] pend;
  logic            uses_rs1;
  logic            uses_rs2;
  logic            wen;
  logic            is_mul;
  logic            hazard;
  logic            byp;
  logic            fire;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  t_seq_num        seq_num;

  // ------------------------------------------------
  // Decoder
  // ------------------------------------------------

  assign raw = inst;

  always_comb begin
    dec.rd  = raw.rd;
    dec.rs1 = raw.rs1;
    dec.rs2 = raw.rs2;
    dec.imm = {{(XLEN-13){raw.imm[12]}}, raw.imm};
    case (raw.opcode)
      OP_ADD, OP_ADDI, OP_MUL: dec.op = t_opcode'(raw.opcode);
      default:                 dec.op = OP_NOP;
    endcase
  end

  assign uses_rs1 = (dec.op != OP_NOP);
  assign uses_rs2 = (dec.op == OP_ADD) || (dec.op == OP_MUL);
  // Writes to r0 are dropped here
  assign wen      = (dec.op != OP_NOP) && (dec.rd != '0);
  assign is_mul   = (dec.op == OP_MUL);

  // ------------------------------------------------
  // Register read with commit bypass
  // ------------------------------------------------

  assign byp = commit.val && commit.wen;

  assign rs1_val = (dec.rs1 == '0) ? '0 :
                   (byp && commit.waddr == dec.rs1) ? commit.wdata : rf[dec.rs1];
  assign rs2_val = (dec.rs2 == '0) ? '0 :
                   (byp && commit.waddr == dec.rs2) ? commit.wdata : rf[dec.rs2];

  // r0 never has wen set, so it is never written
  always_ff @(posedge clk) begin
    if (byp) begin
      rf[commit.waddr] <= commit.wdata;
    end
  end

  // ------------------------------------------------
  // Scoreboard and issue
  // ------------------------------------------------

  assign clr_mask = byp ? (NUM_REGS'(1) << commit.waddr) : '0;
  // Bit clearing this cycle no longer blocks
  assign pend     = sb & ~clr_mask;

  assign hazard = (uses_rs1 && pend[dec.rs1]) ||
                  (uses_rs2 && pend[dec.rs2]) ||
                  (wen && pend[dec.rd]);

  assign inst_rdy = !hazard && (is_mul ? mul_rdy : alu_rdy);
  assign alu_val  = inst_val && !hazard && !is_mul;
  assign mul_val  = inst_val && !hazard && is_mul;
  assign fire     = inst_val && inst_rdy;

  assign set_mask = (fire && wen) ? (NUM_REGS'(1) << dec.rd) : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sb      <= '0;
      seq_num <= '0;
    end else begin
      // Set wins over a same-cycle clear of the same register
      sb <= (sb & ~clr_mask) | set_mask;
      if (fire) begin
        seq_num <= seq_num + 1'b1;
      end
    end
  end

  // Same payload on both channels, valids pick the pipe
  always_comb begin
    iss.pc      = inst_pc;
    iss.op      = dec.op;
    iss.waddr   = dec.rd;
    iss.wen     = wen;
    iss.op_a    = rs1_val;
    iss.op_b    = (dec.op == OP_ADDI) ? dec.imm : rs2_val;
    iss.seq_num = seq_num;
  end

  assign alu_issue = iss;
  assign mul_issue = iss;

  // An older write to a source must not land right after the source was read
  a_no_raw_issue: assert property (@(posedge clk) disable iff (!rst_n)
    fire |=> !(byp && (($past(uses_rs1) && commit.waddr == $past(dec.rs1)) ||
                       ($past(uses_rs2) && commit.waddr == $past(dec.rs2)))))
    else $error("decode_issue: issued with a pending source register");

endmodule

//--- execute/alu.sv
/*
 * Single-cycle ALU pipe for NOP, ADD and ADDI.
 * ADDI immediate already sits in op_b, so ADD and ADDI share one adder.
 */

`timescale 1ns/1ps

module alu
  import blimp_isa_pkg::*;
  import blimp_uarch_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  t_issue  issue,
  input  logic    issue_val,
  output logic    issue_rdy,
  output t_result result,
  output logic    result_val,
  input  logic    result_rdy
);

  t_result alu_out;

  // NOP arrives with wen low and writes zero
  always_comb begin
    alu_out.pc      = issue.pc;
    alu_out.waddr   = issue.waddr;
    alu_out.wen     = issue.wen;
    alu_out.wdata   = (issue.op == OP_NOP) ? '0 : issue.op_a + issue.op_b;
    alu_out.seq_num = issue.seq_num;
  end

  // Result register, one cycle of latency
  pipe_reg #(
    .t_payload (t_result)
  ) out_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_val   (issue_val),
    .in_rdy   (issue_rdy),
    .in_data  (alu_out),
    .out_val  (result_val),
    .out_rdy  (result_rdy),
    .out_data (result)
  );

endmodule

//--- execute/multiplier.sv
/*
 * Pipelined multiplier, low 32 bits of op_a * op_b.
 * Latency is p_mul_stages (1 to 4). Product forms at entry, later stages
 * only delay it, left for retiming. The chain stalls as a whole.
 */

`timescale 1ns/1ps

module multiplier
  import blimp_uarch_pkg::*;
#(
  parameter int p_mul_stages = 3
) (
  input  logic    clk,
  input  logic    rst_n,
  input  t_issue  issue,
  input  logic    issue_val,
  output logic    issue_rdy,
  output t_result result,
  output logic    result_val,
  input  logic    result_rdy
);

  localparam int LAST = p_mul_stages - 1;

  if (p_mul_stages < 1 || p_mul_stages > 4) begin : g_bad_stages
    $error("multiplier: p_mul_stages must be 1 to 4");
  end

  logic [p_mul_stages-1:0] stage_val;
  t_result                 stage_res [p_mul_stages];
  t_result                 entry;
  logic                    advance;

  always_comb begin
    entry.pc      = issue.pc;
    entry.waddr   = issue.waddr;
    entry.wen     = issue.wen;
    entry.wdata   = issue.op_a * issue.op_b;
    entry.seq_num = issue.seq_num;
  end

  // Move only when the tail is empty or leaving
  assign advance   = !stage_val[LAST] || result_rdy;
  assign issue_rdy = advance;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_val <= '0;
    end else if (advance) begin
      stage_val[0] <= issue_val;
      for (int i = 1; i < p_mul_stages; i++) begin
        stage_val[i] <= stage_val[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      stage_res[0] <= entry;
      for (int i = 1; i < p_mul_stages; i++) begin
        stage_res[i] <= stage_res[i-1];
      end
    end
  end

  assign result_val = stage_val[LAST];
  assign result     = stage_res[LAST];

  // Stall must freeze the tail too
  a_tail_hold: assert property (@(posedge clk) disable iff (!rst_n)
    result_val && !result_rdy |=> result_val && $stable(result))
    else $error("multiplier: tail stage moved while stalled");

endmodule

//--- writeback/writeback.sv
/*
 * Writeback. Merges both pipes into one registered commit stream.
 * Fixed priority, multiplier first. Commit order is completion order.
 */

`timescale 1ns/1ps

module writeback
  import blimp_uarch_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  t_result alu_result,
  input  logic    alu_val,
  output logic    alu_rdy,
  input  t_result mul_result,
  input  logic    mul_val,
  output logic    mul_rdy,
  output t_commit commit
);

  logic    commit_val;
  t_result commit_res;

  // Grant is the ready, at most one per cycle
  assign mul_rdy = mul_val;
  assign alu_rdy = !mul_val;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      commit_val <= 1'b0;
    end else begin
      commit_val <= mul_val || alu_val;
    end
  end

  always_ff @(posedge clk) begin
    if (mul_val) begin
      commit_res <= mul_result;
    end else if (alu_val) begin
      commit_res <= alu_result;
    end
  end

  always_comb begin
    commit.val     = commit_val;
    commit.pc      = commit_res.pc;
    commit.waddr   = commit_res.waddr;
    commit.wen     = commit_res.wen;
    commit.wdata   = commit_res.wdata;
    commit.seq_num = commit_res.seq_num;
  end

  // Losing ALU result waits in place for its grant
  a_alu_hold: assert property (@(posedge clk) disable iff (!rst_n)
    alu_val && !alu_rdy |=> alu_val && $stable(alu_result))
    else $error("writeback: ALU result changed while waiting for grant");

endmodule

//--- logic/blimp_basic.sv
/*
 * Core top level: fetch, decode/issue, ALU and multiplier pipes, writeback.
 * Instruction memory must answer each request exactly one cycle later.
 * trace carries every commit, in completion order.
 */

`timescale 1ns/1ps

module blimp_basic
  import blimp_uarch_pkg::*;
#(
  parameter logic [31:0] p_rst_addr   = 32'h0,
  parameter int          p_mul_stages = 3
) (
  input  logic      clk,
  input  logic      rst_n,
  output t_mem_req  imem_req,
  input  t_mem_resp imem_resp,
  output t_commit   trace
);

  // ------------------------------------------------
  // Stage channels
  // ------------------------------------------------

  logic        inst_val;
  logic        inst_rdy;
  logic [31:0] inst;
  logic [31:0] inst_pc;

  t_issue      alu_issue;
  logic        alu_val;
  logic        alu_rdy;
  t_issue      mul_issue;
  logic        mul_val;
  logic        mul_rdy;

  // Multiplier input after its skid register
  t_issue      mul_in;
  logic        mul_in_val;
  logic        mul_in_rdy;

  t_result     alu_result;
  logic        alu_res_val;
  logic        alu_res_rdy;
  t_result     mul_result;
  logic        mul_res_val;
  logic        mul_res_rdy;

  t_commit     commit;

  // ------------------------------------------------
  // Units
  // ------------------------------------------------

  fetch #(
    .p_rst_addr (p_rst_addr)
  ) fetch_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_req  (imem_req),
    .imem_resp (imem_resp),
    .inst_val  (inst_val),
    .inst_rdy  (inst_rdy),
    .inst      (inst),
    .inst_pc   (inst_pc)
  );

  decode_issue decode_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst_val  (inst_val),
    .inst_rdy  (inst_rdy),
    .inst      (inst),
    .inst_pc   (inst_pc),
    .alu_issue (alu_issue),
    .alu_val   (alu_val),
    .alu_rdy   (alu_rdy),
    .mul_issue (mul_issue),
    .mul_val   (mul_val),
    .mul_rdy   (mul_rdy),
    .commit    (commit)
  );

  pipe_reg #(
    .t_payload (t_issue)
  ) mul_in_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_val   (mul_val),
    .in_rdy   (mul_rdy),
    .in_data  (mul_issue),
    .out_val  (mul_in_val),
    .out_rdy  (mul_in_rdy),
    .out_data (mul_in)
  );

  alu alu_pipe (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue      (alu_issue),
    .issue_val  (alu_val),
    .issue_rdy  (alu_rdy),
    .result     (alu_result),
    .result_val (alu_res_val),
    .result_rdy (alu_res_rdy)
  );

  multiplier #(
    .p_mul_stages (p_mul_stages)
  ) mul_pipe (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue      (mul_in),
    .issue_val  (mul_in_val),
    .issue_rdy  (mul_in_rdy),
    .result     (mul_result),
    .result_val (mul_res_val),
    .result_rdy (mul_res_rdy)
  );

  writeback wb_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .alu_result (alu_result),
    .alu_val    (alu_res_val),
    .alu_rdy    (alu_res_rdy),
    .mul_result (mul_result),
    .mul_val    (mul_res_val),
    .mul_rdy    (mul_res_rdy),
    .commit     (commit)
  );

  // Commit stream doubles as the instruction trace
  assign trace = commit;

endmodule

//--- dv/blimp_basic_tb.sv
/*
 * Testbench for the core top level with p_mul_stages = 3.
 * Memory model answers every request one cycle later, NOP past the table.
 * Expected values come from an in-order golden model of the program table.
 */

`timescale 1ns/1ps

module blimp_basic_tb
  import blimp_isa_pkg::*;
  import blimp_uarch_pkg::*;
;

  localparam int NUM_DIRECTED = 20;
  localparam int NUM_INST     = NUM_DIRECTED + 40;
  localparam int CYCLE_LIMIT  = 16 * NUM_INST + 200;

  logic      clk;
  logic      rst_n;
  t_mem_req  imem_req;
  t_mem_resp imem_resp;
  t_commit   trace;

  // Program table, stimulus and expected results side by side
  logic [31:0] prog_inst    [NUM_INST];
  logic [31:0] exp_wdata    [NUM_INST];
  logic        exp_wen      [NUM_INST];
  logic [4:0]  exp_waddr    [NUM_INST];
  int          prod_a       [NUM_INST];
  int          prod_b       [NUM_INST];
  int          commit_cnt   [NUM_INST];
  int          commit_order [NUM_INST];

  int          num_done;
  int          commit_total;
  int          checks;
  int          mismatches;
  int          other_errors;
  int          cycle;

  blimp_basic #(
    .p_rst_addr   (32'h0),
    .p_mul_stages (3)
  ) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_req  (imem_req),
    .imem_resp (imem_resp),
    .trace     (trace)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // Program and golden model
  // --------------------------------------------------

  task automatic build_program();
    int unsigned op_sel;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [12:0] imm;
    // ADDI chain, positive and negative immediates
    prog_inst[0]  = enc_i(OP_ADDI, 5'd1, 5'd0, 13'd100);
    prog_inst[1]  = enc_i(OP_ADDI, 5'd2, 5'd0, 13'h1ff9);  // -7
    prog_inst[2]  = enc_i(OP_ADDI, 5'd3, 5'd0, 13'h0fff);  // largest positive
    prog_inst[3]  = enc_i(OP_ADDI, 5'd4, 5'd0, 13'h1000);  // -4096
    // Back-to-back dependent ADDs
    prog_inst[4]  = enc_r(OP_ADD, 5'd5, 5'd1, 5'd2);
    prog_inst[5]  = enc_r(OP_ADD, 5'd6, 5'd5, 5'd5);
    // MUL chain, last product overflows 32 bits
    prog_inst[6]  = enc_r(OP_MUL, 5'd7, 5'd1, 5'd3);
    prog_inst[7]  = enc_i(OP_ADDI, 5'd8, 5'd0, 13'd4000);
    prog_inst[8]  = enc_r(OP_MUL, 5'd9, 5'd8, 5'd8);
    prog_inst[9]  = enc_r(OP_MUL, 5'd10, 5'd9, 5'd9);
    prog_inst[10] = enc_r(OP_ADD, 5'd11, 5'd10, 5'd7);
    prog_inst[11] = enc_r(OP_MUL, 5'd12, 5'd11, 5'd2);
    // r0 as target and as source
    prog_inst[12] = enc_i(OP_ADDI, 5'd0, 5'd1, 13'd55);
    prog_inst[13] = enc_r(OP_ADD, 5'd13, 5'd0, 5'd1);
    prog_inst[14] = 32'h0;
    prog_inst[15] = enc_r(OP_MUL, 5'd0, 5'd1, 5'd1);
    prog_inst[16] = enc_r(OP_ADD, 5'd14, 5'd0, 5'd0);
    // Self update, then mixed consumers
    prog_inst[17] = enc_i(OP_ADDI, 5'd1, 5'd1, 13'h1fff);
    prog_inst[18] = enc_r(OP_ADD, 5'd15, 5'd1, 5'd12);
    prog_inst[19] = enc_r(OP_MUL, 5'd16, 5'd15, 5'd4);
    // Random block over r0 to r7 for dense hazards
    for (int i = NUM_DIRECTED; i < NUM_INST; i++) begin
      op_sel = $urandom_range(3, 0);
      rd     = 5'($urandom_range(7, 0));
      rs1    = 5'($urandom_range(7, 0));
      rs2    = 5'($urandom_range(7, 0));
      imm    = 13'($urandom);
      if (op_sel == 2) begin
        prog_inst[i] = enc_i(OP_ADDI, rd, rs1, imm);
      end else begin
        prog_inst[i] = enc_r(t_opcode'(op_sel), rd, rs1, rs2);
      end
    end
  endtask

  // In-order reference, also records the producer of each source
  task automatic run_golden_model();
    logic [31:0] regs        [32];
    int          last_writer [32];
    logic [3:0]  op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic [31:0] val;
    for (int r = 0; r < 32; r++) begin
      regs[r]        = 32'h0;
      last_writer[r] = -1;
    end
    for (int i = 0; i < NUM_INST; i++) begin
      op        = prog_inst[i][31:28];
      rd        = prog_inst[i][27:23];
      rs1       = prog_inst[i][22:18];
      rs2       = prog_inst[i][17:13];
      imm       = {{19{prog_inst[i][12]}}, prog_inst[i][12:0]};
      prod_a[i] = -1;
      prod_b[i] = -1;
      case (op)
        OP_ADD: begin
          val       = regs[rs1] + regs[rs2];
          prod_a[i] = last_writer[rs1];
          prod_b[i] = last_writer[rs2];
        end
        OP_ADDI: begin
          val       = regs[rs1] + imm;
          prod_a[i] = last_writer[rs1];
        end
        OP_MUL: begin
          val       = regs[rs1] * regs[rs2];
          prod_a[i] = last_writer[rs1];
          prod_b[i] = last_writer[rs2];
        end
        default: val = 32'h0;
      endcase
      exp_wdata[i] = val;
      exp_wen[i]   = (op == OP_ADD || op == OP_ADDI || op == OP_MUL) && (rd != 5'd0);
      exp_waddr[i] = rd;
      // r0 stays zero
      if (exp_wen[i]) begin
        regs[rd]        = val;
        last_writer[rd] = i;
      end
    end
  endtask

  function automatic logic [31:0] fetch_word(logic [31:0] addr);
    if (addr[1:0] == 2'b00 && addr < 32'(NUM_INST * 4)) begin
      return prog_inst[addr >> 2];
    end
    return {OP_NOP, 28'h0};
  endfunction

  // --------------------------------------------------
  // Memory model and trace checks
  // --------------------------------------------------

  // Request seen mid-cycle, answered just after the next edge
  initial begin : imem_model
    logic        req_seen;
    logic [31:0] req_addr;
    imem_resp = '0;
    forever begin
      @(negedge clk);
      req_seen = imem_req.val;
      req_addr = imem_req.addr;
      @(posedge clk);
      #1;
      imem_resp.val  = req_seen;
      imem_resp.data = fetch_word(req_addr);
    end
  end

  task automatic check_commit(t_commit c);
    int idx;
    if (c.pc[1:0] != 2'b00 || c.pc >= 32'(NUM_INST * 4)) begin
      // Padding NOP past the program
      if (c.wen) begin
        $display("ERROR: NOP past the program at pc %h committed with a write", c.pc);
        other_errors++;
      end
    end else begin
      idx = int'(c.pc >> 2);
      checks++;
      if (commit_cnt[idx] != 0) begin
        $display("ERROR: instruction at pc %h committed more than once", c.pc);
        other_errors++;
      end else begin
        commit_order[idx] = commit_total;
        num_done++;
      end
      commit_cnt[idx]++;
      if (c.wdata !== exp_wdata[idx]) begin
        $display("MISMATCH pc=%h trace.wdata got %h expected %h", c.pc, c.wdata,
                 exp_wdata[idx]);
        mismatches++;
      end
      if (c.wen !== exp_wen[idx]) begin
        $display("MISMATCH pc=%h trace.wen got %h expected %h", c.pc, c.wen, exp_wen[idx]);
        mismatches++;
      end
      if (exp_wen[idx] && c.waddr !== exp_waddr[idx]) begin
        $display("MISMATCH pc=%h trace.waddr got %h expected %h", c.pc, c.waddr,
                 exp_waddr[idx]);
        mismatches++;
      end
      // Issue runs in table order from reset, stamps wrap with the counter
      if (c.seq_num !== t_seq_num'(idx)) begin
        $display("MISMATCH pc=%h trace.seq_num got %h expected %h", c.pc, c.seq_num,
                 t_seq_num'(idx));
        mismatches++;
      end
    end
    commit_total++;
  endtask

  always @(negedge clk) begin
    if (rst_n && trace.val) begin
      check_commit(trace);
    end
  end

  // Each entry once, never ahead of its producers
  task automatic check_commit_order();
    for (int i = 0; i < NUM_INST; i++) begin
      if (commit_cnt[i] != 1) begin
        $display("ERROR: instruction %0d committed %0d times", i, commit_cnt[i]);
        other_errors++;
      end else begin
        if (prod_a[i] >= 0 && commit_order[prod_a[i]] > commit_order[i]) begin
          $display("ERROR: instruction %0d committed before producer %0d", i, prod_a[i]);
          other_errors++;
        end
        if (prod_b[i] >= 0 && commit_order[prod_b[i]] > commit_order[i]) begin
          $display("ERROR: instruction %0d committed before producer %0d", i, prod_b[i]);
          other_errors++;
        end
      end
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    rst_n        = 1'b0;
    num_done     = 0;
    commit_total = 0;
    checks       = 0;
    mismatches   = 0;
    other_errors = 0;
    void'($urandom(32'h1ac1));
    for (int i = 0; i < NUM_INST; i++) begin
      commit_cnt[i]   = 0;
      commit_order[i] = -1;
    end
    build_program();
    run_golden_model();

    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    cycle = 0;
    while (num_done < NUM_INST && cycle < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle++;
    end
    if (num_done < NUM_INST) begin
      $display("ERROR: timeout after %0d cycles, %0d of %0d instructions committed",
               cycle, num_done, NUM_INST);
      other_errors++;
    end
    check_commit_order();

    $display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
             other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- sim.f
common/blimp_isa_pkg.sv
common/blimp_uarch_pkg.sv
logic/pipe_reg.sv
fetch/fetch.sv
decode/decode_issue.sv
execute/alu.sv
execute/multiplier.sv
writeback/writeback.sv
logic/blimp_basic.sv
dv/blimp_basic_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module blimp_basic_tb --Mdir "$BUILD_DIR" -o blimp_basic_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$BUILD_DIR/blimp_basic_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0
